/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module attr_tb \
		-f vlog.f -o attr_sim
	./obj_dir/attr_sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/attr_pkg.sv */
package attr_pkg;

  // **************************************************
  // sizes and register map
  // **************************************************
  localparam int num_planes = 4;
  localparam int pan_w      = 4;
  localparam int color_w    = 6;
  localparam int pal_depth  = 16;

  localparam logic [4:0] reg_pan_idx  = 5'h13;  // horizontal pixel panning.
  localparam logic [4:0] reg_mode_idx = 5'h10;  // mode control.
  localparam logic [4:0] reg_pal_base = 5'h00;  // palette occupies 16 indices from here.

  // bit of the mode register data that selects 256-colour mode.
  localparam int mode_13_bit = 6;

  // **************************************************
  // data types
  // **************************************************
  typedef struct packed {
    logic [7:0] plane3;
    logic [7:0] plane2;
    logic [7:0] plane1;
    logic [7:0] plane0;
  } plane_bytes_t;

  typedef struct packed {
    logic [3:0]       rsvd;
    logic [pan_w-1:0] pp_ctl;
  } pan_fields_t;

  typedef struct packed {
    logic [1:0]         rsvd;
    logic [color_w-1:0] color;
  } pal_fields_t;

  // the write data byte means different things per register.
  typedef union packed {
    pan_fields_t pan;
    pal_fields_t pal;
  } reg_data_u;

  typedef struct packed {
    logic       strobe;
    logic [4:0] idx;
    reg_data_u  data;
  } reg_wr_t;

  typedef struct packed {
    logic               strobe;
    logic [3:0]         addr;
    logic [color_w-1:0] color;
  } pal_wr_t;

  typedef struct packed {
    logic [pan_w-1:0] pp_ctl;
    logic             mode_13;
    logic             by_4_syn_cclk;  // character phase for panning value 0.
  } pan_ctl_t;

endpackage

/* palette/palette_lookup.sv */
`timescale 1ns/1ps

module palette_lookup (
  input  logic                     clk,
  input  logic                     r_n,
  input  attr_pkg::pal_wr_t        pal_wr,
  input  logic [3:0]               index,
  input  logic                     dot_en,
  output logic [attr_pkg::color_w-1:0] color,
  output logic                     color_vld
);

  import attr_pkg::*;

  logic [color_w-1:0] pal_mem [pal_depth];
  logic [color_w-1:0] rd_data;

  // **************************************************
  // palette storage
  // **************************************************
  always_ff @(posedge clk or negedge r_n) begin
    if (!r_n) begin
      for (int i = 0; i < pal_depth; i++) begin
        pal_mem[i] <= '0;
      end
    end else if (pal_wr.strobe) begin
      pal_mem[pal_wr.addr] <= pal_wr.color;
    end
  end

  // the read sees the array before this edge's write.
  assign rd_data = pal_mem[index];

  // **************************************************
  // colour output
  // **************************************************
  always_ff @(posedge clk or negedge r_n) begin
    if (!r_n) begin
      color     <= '0;
      color_vld <= 1'b0;
    end else begin
      color_vld <= dot_en;                 // one pulse per dot.
      if (dot_en) begin
        color <= rd_data;
      end
    end
  end

endmodule

/* serializer/pixel_panning.sv */
`timescale 1ns/1ps

module pixel_panning (
  input  logic               clk,
  input  logic               r_n,
  input  logic               din,
  input  logic               clk_en,
  input  attr_pkg::pan_ctl_t pan_ctl,
  output logic               dout
);

  logic [8:0] shift_ff;
  logic [7:0] mux_ctl;
  logic [7:0] mux_ctl_hi;
  logic [7:0] int_d;

  // **************************************************
  // delay chain
  // **************************************************
  // din enters stage 8 every dot and also at the stage that mux_ctl
  // picks, so the delay to dout is the tap number plus one.
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      int_d[i] = mux_ctl[i] ? din : shift_ff[i+1];
    end
  end

  always_ff @(posedge clk or negedge r_n) begin
    if (!r_n) begin
      shift_ff <= 9'b0;
    end else if (clk_en) begin
      shift_ff <= {din, int_d};
    end
  end

  assign dout = shift_ff[0];

  // **************************************************
  // tap select
  // **************************************************
  // values 8 to 15 only move the picture in 256-colour mode.
  assign mux_ctl_hi = pan_ctl.mode_13 ? 8'b0001_0000 : 8'b0000_0000;

  always_comb begin
    case (pan_ctl.pp_ctl)
      4'h0:    mux_ctl = (pan_ctl.mode_13 && pan_ctl.by_4_syn_cclk) ? 8'b0000_1000
                                                                  : 8'b1000_0000;
      4'h1:    mux_ctl = 8'b0100_0000;
      4'h2:    mux_ctl = pan_ctl.mode_13 ? 8'b0100_0000 : 8'b0010_0000;
      4'h3:    mux_ctl = 8'b0001_0000;
      4'h4:    mux_ctl = pan_ctl.mode_13 ? 8'b0010_0000 : 8'b0000_1000;
      4'h5:    mux_ctl = 8'b0000_0100;
      4'h6:    mux_ctl = pan_ctl.mode_13 ? 8'b0001_0000 : 8'b0000_0010;
      4'h7:    mux_ctl = 8'b0000_0001;  // shortest delay.
      default: mux_ctl = mux_ctl_hi;
    endcase
  end

  // **************************************************
  // checks
  // **************************************************
  // two taps would mix pixels from different dots.
  a_mux_onehot: assert property (
    @(posedge clk) disable iff (!r_n)
    $onehot0(mux_ctl)
  );

endmodule

/* serializer/plane_serializer.sv */
`timescale 1ns/1ps

module plane_serializer (
  input  logic                   clk,
  input  logic                   r_n,
  input  logic                   load,
  input  attr_pkg::plane_bytes_t planes,
  input  logic                   dot_en,
  output logic [3:0]             bits
);

  import attr_pkg::*;

  logic [num_planes-1:0][7:0] plane_arr;
  logic [7:0]                 shift_q [num_planes];

  assign plane_arr = planes;  // plane0 lands at index 0.

  // **************************************************
  // per-plane shift registers
  // **************************************************
  for (genvar p = 0; p < num_planes; p++) begin : g_plane
    always_ff @(posedge clk or negedge r_n) begin
      if (!r_n) begin
        shift_q[p] <= 8'h00;
      end else if (load) begin
        shift_q[p] <= plane_arr[p];        // a new byte beats a pending dot.
      end else if (dot_en) begin
        shift_q[p] <= {shift_q[p][6:0], 1'b0};
      end
    end

    assign bits[p] = shift_q[p][7];        // leftmost pixel first.
  end

  // **************************************************
  // checks
  // **************************************************
  // When load and a dot coincide, the dot is dropped and the new
  // character shows its first pixel.
  a_load_priority: assert property (
    @(posedge clk) disable iff (!r_n)
    (load && dot_en) |=> bits == $past({planes.plane3[7], planes.plane2[7],
                                        planes.plane1[7], planes.plane0[7]})
  );

endmodule

/* source/attr_ctl.sv */
`timescale 1ns/1ps

module attr_ctl (
  input  logic               clk,
  input  logic               r_n,
  input  attr_pkg::reg_wr_t  reg_wr,
  input  logic               load,
  input  logic               dot_en,
  output attr_pkg::pal_wr_t  pal_wr,
  output attr_pkg::pan_ctl_t pan_ctl
);

  import attr_pkg::*;

  logic [4:0]       pal_off;
  logic [7:0]       wr_byte;
  logic             pan_sel;
  logic             mode_sel;
  logic [pan_w-1:0] pp_ctl_q;
  logic             mode_13_q;
  logic [2:0]       dot_cnt;

  // **************************************************
  // register write decode
  // **************************************************
  assign wr_byte  = reg_wr.data;                   // raw byte, mode select is a single bit.
  assign pal_off  = reg_wr.idx - reg_pal_base;     // wraps high below the base.
  assign pan_sel  = reg_wr.strobe && (reg_wr.idx == reg_pan_idx);
  assign mode_sel = reg_wr.strobe && (reg_wr.idx == reg_mode_idx);

  // palette writes pass straight through in the same cycle.
  always_comb begin
    pal_wr.strobe = reg_wr.strobe && (pal_off < pal_depth);
    pal_wr.addr   = pal_off[3:0];
    pal_wr.color  = reg_wr.data.pal.color;
  end

  // **************************************************
  // panning and mode registers
  // **************************************************
  always_ff @(posedge clk or negedge r_n) begin
    if (!r_n) begin
      pp_ctl_q  <= '0;
      mode_13_q <= 1'b0;
    end else begin
      if (pan_sel) begin
        pp_ctl_q <= reg_wr.data.pan.pp_ctl;
      end
      if (mode_sel) begin
        mode_13_q <= wr_byte[mode_13_bit];
      end
    end
  end

  // **************************************************
  // dot counter
  // **************************************************
  // Counts dots inside the character. A load starts a new character,
  // so the count goes back to zero there even if a dot is pending.
  always_ff @(posedge clk or negedge r_n) begin
    if (!r_n) begin
      dot_cnt <= 3'd0;
    end else if (load) begin
      dot_cnt <= 3'd0;
    end else if (dot_en) begin
      dot_cnt <= dot_cnt + 3'd1;
    end
  end

  // in mode 13 four dots make one pixel, bit 2 marks the second half.
  assign pan_ctl = '{
    pp_ctl:        pp_ctl_q,
    mode_13:       mode_13_q,
    by_4_syn_cclk: dot_cnt[2]
  };

  // **************************************************
  // checks
  // **************************************************
  // a palette write only ever comes from a host write.
  a_pal_wr_src: assert property (
    @(posedge clk) disable iff (!r_n)
    $rose(pal_wr.strobe) |-> reg_wr.strobe
  );

endmodule

/* source/attr_top.sv */
`timescale 1ns/1ps

module attr_top (
  input  logic                         clk,
  input  logic                         r_n,
  input  attr_pkg::reg_wr_t            reg_wr,
  input  logic                         load,
  input  attr_pkg::plane_bytes_t       planes,
  input  logic                         dot_en,
  output logic [attr_pkg::color_w-1:0] color,
  output logic                         color_vld
);

  import attr_pkg::*;

  pal_wr_t               pal_wr;
  pan_ctl_t              pan_ctl;
  logic [num_planes-1:0] ser_bits;
  logic [num_planes-1:0] pal_index;  // plane 3 is the index MSB.

  // **************************************************
  // control
  // **************************************************
  attr_ctl u_ctl (
    .clk     (clk),
    .r_n     (r_n),
    .reg_wr  (reg_wr),
    .load    (load),
    .dot_en  (dot_en),
    .pal_wr  (pal_wr),
    .pan_ctl (pan_ctl)
  );

  // **************************************************
  // pixel path
  // **************************************************
  plane_serializer u_ser (
    .clk    (clk),
    .r_n    (r_n),
    .load   (load),
    .planes (planes),
    .dot_en (dot_en),
    .bits   (ser_bits)
  );

  // every plane gets the same panning, so the planes stay aligned.
  for (genvar p = 0; p < num_planes; p++) begin : g_pan
    pixel_panning u_pan (
      .clk     (clk),
      .r_n     (r_n),
      .din     (ser_bits[p]),
      .clk_en  (dot_en),
      .pan_ctl (pan_ctl),
      .dout    (pal_index[p])
    );
  end

  palette_lookup u_pal (
    .clk       (clk),
    .r_n       (r_n),
    .pal_wr    (pal_wr),
    .index     (pal_index),
    .dot_en    (dot_en),
    .color     (color),
    .color_vld (color_vld)
  );

endmodule

/* tests/attr_tb.sv */
`timescale 1ns/1ps

module attr_tb;

  import attr_pkg::*;

  localparam int clk_period = 40;
  localparam int drive_dly  = 1;

  logic               clk;
  logic               r_n;
  reg_wr_t            reg_wr;
  logic               load;
  plane_bytes_t       planes;
  logic               dot_en;
  logic [color_w-1:0] color;
  logic               color_vld;

  byte         op_kind [$];  // W, L or D, one entry per single operation.
  logic [31:0] op_arg  [$];
  bit          ops_ready;
  int          dot_total;
  int          vld_count;

  attr_top DUT (
    .clk       (clk),
    .r_n       (r_n),
    .reg_wr    (reg_wr),
    .load      (load),
    .planes    (planes),
    .dot_en    (dot_en),
    .color     (color),
    .color_vld (color_vld)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // **************************************************
  // helpers
  // **************************************************
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_dly;
  endtask

  task automatic check_color(input logic [color_w-1:0] act,
                             input logic [color_w-1:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("ERROR: color = 0x%02h, expected 0x%02h", act, exp));
    end
  endtask

  task automatic check_vld(input bit act, input bit exp);
    if (act != exp) begin
      fail_run($sformatf("ERROR: color_vld = 0x%0h, expected 0x%0h", act, exp));
    end
  endtask

  // a D line carries a run of dots, each one becomes its own operation.
  task automatic read_tests();
    int               fd;
    int               n;
    int               cnt;
    byte              kind;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [7:0]       pl [4];
    logic [8*100-1:0] rest;

    fd = $fopen("tests/attr_tests.txt", "r");
    if (fd == 0) begin
      fail_run("could not open tests/attr_tests.txt");
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": n = $fgets(rest, fd);
        "W": begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2) begin
            fail_run("a register write record in the test file is incomplete");
          end
          op_kind.push_back(kind);
          op_arg.push_back({16'h0, a[7:0], b[7:0]});
        end
        "L": begin
          n = $fscanf(fd, "%h %h %h %h", pl[3], pl[2], pl[1], pl[0]);
          if (n != 4) begin
            fail_run("a plane load record in the test file is incomplete");
          end
          op_kind.push_back(kind);
          op_arg.push_back({pl[3], pl[2], pl[1], pl[0]});
        end
        "D": begin
          n = $fscanf(fd, "%h", cnt);
          if (n != 1) begin
            fail_run("a dot record in the test file has no dot count");
          end
          for (int i = 0; i < cnt; i++) begin
            n = $fscanf(fd, "%h", a);
            if (n != 1) begin
              fail_run("a dot record in the test file has too few colours");
            end
            op_kind.push_back(kind);
            op_arg.push_back(a);
          end
          dot_total += cnt;
        end
        default: fail_run($sformatf("the test file holds an unknown record kind %c", kind));
      endcase
    end
    $fclose(fd);
  endtask

  task automatic run_op(input byte kind, input logic [31:0] arg);
    case (kind)
      "W": begin
        reg_wr = {1'b1, arg[12:8], arg[7:0]};
        next_cycle();
        reg_wr = '0;
        check_vld(color_vld, 1'b0);
      end
      "L": begin
        planes = arg;
        load   = 1'b1;
        next_cycle();
        load   = 1'b0;
        check_vld(color_vld, 1'b0);
      end
      default: begin
        dot_en = 1'b1;
        next_cycle();
        dot_en = 1'b0;
        check_vld(color_vld, 1'b1);          // one cycle after the dot edge.
        check_color(color, arg[color_w-1:0]);
      end
    endcase
  endtask

  // **************************************************
  // stimulus
  // **************************************************
  initial begin
    int gap;

    r_n    = 1'b0;
    reg_wr = '0;
    load   = 1'b0;
    planes = '0;
    dot_en = 1'b0;
    void'($urandom(51));
    read_tests();
    ops_ready = 1'b1;
    repeat (2) begin
      next_cycle();
      check_vld(color_vld, 1'b0);
    end
    r_n = 1'b1;
    repeat (3) begin
      next_cycle();
      check_vld(color_vld, 1'b0);            // no colour before the first dot.
    end
    foreach (op_kind[i]) begin
      run_op(op_kind[i], op_arg[i]);
      gap = $urandom % 3;
      repeat (gap) begin
        next_cycle();
        check_vld(color_vld, 1'b0);
      end
    end
    repeat (2) begin
      next_cycle();
      check_vld(color_vld, 1'b0);
    end
    if (vld_count == dot_total) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      fail_run($sformatf("color_vld was high %0d times for %0d dots", vld_count, dot_total));
    end
  end

  // the valid pulse is stable at the falling edge.
  always @(negedge clk) begin
    if (color_vld) begin
      vld_count++;
    end
  end

  initial begin
    wait (ops_ready);
    #((op_kind.size() + 20) * 8 * clk_period);
    fail_run("timeout: the test records did not finish in the expected time");
  end

endmodule

/* tests/attr_tests.txt */
# W idx data = register write, L plane3 plane2 plane1 plane0 = plane load
# D count colours = a run of dots with the expected colour of each, all fields in hex
D 03 00 00 00
W 08 D1
W 09 22
W 0A 33
W 0B C4
W 0C 15
W 0D 26
W 0E 37
W 0F 7F
W 13 F7
L FF 0F 33 55
D 12 00 11 22 33 04 15 26 37 3F 00 00 00 00 00 00 00 00 00
W 13 A4
W 11 07
W 1F 40
L FF 0F 33 55
D 12 00 00 00 00 11 22 33 04 15 26 37 3F 00 00 00 00 00 00
W 13 01
L FF 0F 33 55
D 12 00 00 00 00 00 00 00 11 22 33 04 15 26 37 3F 00 00 00
W 13 05
L FF 0F 33 55
D 12 00 00 00 11 22 33 04 15 26 37 3F 00 00 00 00 00 00 00
W 13 0B
L FF 0F 33 55
D 12 00 00 00 00 00 00 00 00 00 11 22 33 04 15 26 37 3F 00
W 10 40
W 13 02
L FF 0F 33 55
D 12 00 00 00 00 00 00 00 11 22 33 04 15 26 37 3F 00 00 00
W 13 00
L FF 0F 33 55
D 12 00 00 00 00 00 00 00 00 15 26 37 3F 04 15 26 37 00 00
W 13 0C
L FF 0F 33 55
D 12 00 00 00 00 00 11 22 33 04 15 26 37 3F 00 00 00 00 00

/* vlog.f */
common/attr_pkg.sv
source/attr_ctl.sv
serializer/plane_serializer.sv
serializer/pixel_panning.sv
palette/palette_lookup.sv
source/attr_top.sv
tests/attr_tb.sv
